//--- rtl/deoxys_cfg.svh
`ifndef DEOXYS_CFG_SVH
`define DEOXYS_CFG_SVH

// State and tweakey lane width
`define DEOXYS_BLOCK_W 128

`define DEOXYS_BYTE_W 8

// Fixed round count of the iterative core
`define DEOXYS_ROUNDS 16

`define DEOXYS_RCON_FINAL 8'h72   // Constant of the last round key

`endif

//--- rtl/deoxys_pkg.sv
`default_nettype none
`include "deoxys_cfg.svh"

package deoxys_pkg;

   typedef logic [`DEOXYS_BLOCK_W-1:0] block_t;   // Byte 15 on top, bytes 15..12 are row word 3
   typedef logic [`DEOXYS_BYTE_W-1:0]  byte_t;

   typedef struct packed {
      block_t key;
      block_t tweak;
      block_t cnt;
   } tweakey_t;

   typedef struct packed {
      tweakey_t tk;
      block_t   pt;
   } job_t;

   typedef logic [$clog2(`DEOXYS_ROUNDS+1)-1:0] round_idx_t;

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      DONE
   } ctrl_state_e;

   // Indexed by round, entry 16 belongs to the final key add
   localparam byte_t RCON [0:`DEOXYS_ROUNDS] = '{
      8'h2f, 8'h5e, 8'hbc, 8'h63, 8'hc6, 8'h97, 8'h35, 8'h6a,
      8'hd4, 8'hb3, 8'h7d, 8'hfa, 8'hef, 8'hc5, 8'h91, 8'h39,
      `DEOXYS_RCON_FINAL
   };

endpackage

`default_nettype wire

//--- rtl/deoxys_sbox.sv
`timescale 1ns/1ns
`default_nettype none

module deoxys_sbox (
   input  deoxys_pkg::byte_t din,
   output deoxys_pkg::byte_t dout
);

   logic [0:7]   x;    // x[0] is the MSB
   logic [21:1]  y;
   logic         c0;
   logic         c1;
   logic [45:2]  m;
   logic [0:8]   inv;
   logic [0:17]  z;
   logic [67:46] n;
   logic [0:7]   s;

   assign x = din;

   // Linear top layer
   always_comb begin
      y[14] = x[3] ^ x[5];
      y[13] = x[0] ^ x[6];
      y[9]  = x[0] ^ x[3];
      y[8]  = x[0] ^ x[5];
      c0    = x[1] ^ x[2];
      y[1]  = c0 ^ x[7];
      y[4]  = y[1] ^ x[3];
      y[12] = y[13] ^ y[14];
      y[2]  = y[1] ^ x[0];
      y[5]  = y[1] ^ x[6];
      y[3]  = y[5] ^ y[8];
      c1    = x[4] ^ y[12];
      y[15] = c1 ^ x[5];
      y[20] = c1 ^ x[1];
      y[6]  = y[15] ^ x[7];
      y[10] = y[15] ^ c0;
      y[11] = y[20] ^ y[9];
      y[7]  = x[7] ^ y[11];
      y[17] = y[10] ^ y[11];
      y[19] = y[10] ^ y[8];
      y[16] = c0 ^ y[11];
      y[21] = y[13] ^ y[16];
      y[18] = x[0] ^ y[16];
   end

   // Shared GF(2^4) inversion
   always_comb begin
      m[2]  = y[12] & y[15];
      m[3]  = y[3] & y[6];
      m[4]  = m[3] ^ m[2];
      m[5]  = y[4] & x[7];
      m[6]  = m[5] ^ m[2];
      m[7]  = y[13] & y[16];
      m[8]  = y[5] & y[1];
      m[9]  = m[8] ^ m[7];
      m[10] = y[2] & y[7];
      m[11] = m[10] ^ m[7];
      m[12] = y[9] & y[11];
      m[13] = y[14] & y[17];
      m[14] = m[13] ^ m[12];
      m[15] = y[8] & y[10];
      m[16] = m[15] ^ m[12];
      m[17] = m[4] ^ m[14];
      m[18] = m[6] ^ m[16];
      m[19] = m[9] ^ m[14];
      m[20] = m[11] ^ m[16];
      m[21] = m[17] ^ y[20];
      m[22] = m[18] ^ y[19];
      m[23] = m[19] ^ y[21];
      m[24] = m[20] ^ y[18];
      m[25] = m[21] ^ m[22];
      m[26] = m[21] & m[23];
      m[27] = m[24] ^ m[26];
      m[28] = m[25] & m[27];
      m[29] = m[28] ^ m[22];
      m[30] = m[23] ^ m[24];
      m[31] = m[22] ^ m[26];
      m[32] = m[31] & m[30];
      m[33] = m[32] ^ m[24];
      m[34] = m[23] ^ m[33];
      m[35] = m[27] ^ m[33];
      m[36] = m[24] & m[35];
      m[37] = m[36] ^ m[34];
      m[38] = m[27] ^ m[36];
      m[39] = m[29] & m[38];
      m[40] = m[25] ^ m[39];
      m[41] = m[40] ^ m[37];
      m[42] = m[29] ^ m[33];
      m[43] = m[29] ^ m[40];
      m[44] = m[33] ^ m[37];
      m[45] = m[42] ^ m[41];
   end

   // Both product rows share the same inverse terms
   assign inv = {m[44], m[37], m[33], m[43], m[40], m[29], m[42], m[45], m[41]};
   assign z   = {inv & {y[15], y[6], x[7], y[16], y[1], y[7], y[11], y[17], y[10]},
                 inv & {y[12], y[3], y[4], y[13], y[5], y[2], y[9], y[14], y[8]}};

   // Linear bottom layer, affine constant folded into the inversions
   always_comb begin
      n[46] = z[15] ^ z[16];
      n[47] = z[10] ^ z[11];
      n[48] = z[5] ^ z[13];
      n[49] = z[9] ^ z[10];
      n[50] = z[2] ^ z[12];
      n[51] = z[2] ^ z[5];
      n[52] = z[7] ^ z[8];
      n[53] = z[0] ^ z[3];
      n[54] = z[6] ^ z[7];
      n[55] = z[16] ^ z[17];
      n[56] = z[12] ^ n[48];
      n[57] = n[50] ^ n[53];
      n[58] = z[4] ^ n[46];
      n[59] = z[3] ^ n[54];
      n[60] = n[46] ^ n[57];
      n[61] = z[14] ^ n[57];
      n[62] = n[52] ^ n[58];
      n[63] = n[49] ^ n[58];
      n[64] = z[4] ^ n[59];
      n[65] = n[61] ^ n[62];
      n[66] = z[1] ^ n[63];
      n[67] = n[64] ^ n[65];
      s[0]  = n[59] ^ n[63];
      s[6]  = ~n[56] ^ n[62];
      s[7]  = ~n[48] ^ n[60];
      s[3]  = n[53] ^ n[66];
      s[4]  = n[51] ^ n[66];
      s[5]  = n[47] ^ n[65];
      s[1]  = ~n[64] ^ s[3];
      s[2]  = ~n[55] ^ n[67];
   end

   assign dout = s;

endmodule

`default_nettype wire

//--- rtl/deoxys_round.sv
`timescale 1ns/1ns
`default_nettype none
`include "deoxys_cfg.svh"

module deoxys_round (
   input  deoxys_pkg::block_t state,
   input  deoxys_pkg::block_t round_key,
   output deoxys_pkg::block_t round_out
);

   localparam int BW     = `DEOXYS_BYTE_W;
   localparam int NBYTES = `DEOXYS_BLOCK_W / `DEOXYS_BYTE_W;

   deoxys_pkg::block_t      atk;
   wire deoxys_pkg::block_t sb;
   logic [3:0][31:0]        sr;   // Row words, word 3 on top
   logic [3:0][31:0]        x2;
   logic [3:0][31:0]        mc;

   // AES xtime on each byte of a row word
   function automatic logic [31:0] xtime_w(input logic [31:0] w);
      logic [31:0] r;
      for (int b = 0; b < 4; b++) begin
         r[8*b +: 8] = {w[8*b +: 7], 1'b0} ^ (w[8*b+7] ? 8'h1b : 8'h00);
      end
      return r;
   endfunction

   assign atk = state ^ round_key;

   for (genvar i = 0; i < NBYTES; i++) begin : g_sbox
      deoxys_sbox u_sbox (
         .din  (atk[i*BW +: BW]),
         .dout (sb[i*BW +: BW])
      );
   end

   // Word 2 left by one byte, word 1 by two, word 0 by three
   assign sr = {sb[127:96],
                sb[87:64], sb[95:88],
                sb[47:32], sb[63:48],
                sb[7:0],   sb[31:8]};

   always_comb begin
      for (int k = 0; k < 4; k++) begin
         x2[k] = xtime_w(sr[k]);
      end
      // 2*r(k) ^ 3*r(k-1) ^ r(k-2) ^ r(k-3)
      for (int k = 0; k < 4; k++) begin
         mc[k] = x2[k] ^ x2[(k+3)%4] ^ sr[(k+3)%4] ^ sr[(k+2)%4] ^ sr[(k+1)%4];
      end
   end

   assign round_out = mc;

endmodule

`default_nettype wire

//--- rtl/deoxys_tweakey.sv
`timescale 1ns/1ns
`default_nettype none
`include "deoxys_cfg.svh"

module deoxys_tweakey (
   input  deoxys_pkg::tweakey_t   lanes,
   input  deoxys_pkg::round_idx_t round_idx,
   output deoxys_pkg::block_t     round_key,
   output deoxys_pkg::tweakey_t   next_lanes
);

   localparam int BW     = `DEOXYS_BYTE_W;
   localparam int NBYTES = `DEOXYS_BLOCK_W / `DEOXYS_BYTE_W;

   // Source byte of h, listed for output byte 0 up to 15
   localparam int H_PERM [NBYTES] = '{6, 7, 4, 5, 9, 10, 11, 8, 12, 13, 14, 15, 3, 0, 1, 2};

   deoxys_pkg::byte_t  rc;
   deoxys_pkg::block_t rc_word;

   function automatic deoxys_pkg::block_t perm_h(input deoxys_pkg::block_t b);
      deoxys_pkg::block_t r;
      for (int i = 0; i < NBYTES; i++) begin
         r[i*BW +: BW] = b[H_PERM[i]*BW +: BW];
      end
      return r;
   endfunction

   // Key lane, shift right
   function automatic deoxys_pkg::block_t lfsr3(input deoxys_pkg::block_t b);
      deoxys_pkg::block_t r;
      deoxys_pkg::byte_t  v;
      for (int i = 0; i < NBYTES; i++) begin
         v = b[i*BW +: BW];
         r[i*BW +: BW] = {v[0] ^ v[6], v[7:1]};
      end
      return r;
   endfunction

   // Tweak lane, shift left
   function automatic deoxys_pkg::block_t lfsr2(input deoxys_pkg::block_t b);
      deoxys_pkg::block_t r;
      deoxys_pkg::byte_t  v;
      for (int i = 0; i < NBYTES; i++) begin
         v = b[i*BW +: BW];
         r[i*BW +: BW] = {v[6:0], v[7] ^ v[5]};
      end
      return r;
   endfunction

   assign rc      = deoxys_pkg::RCON[round_idx];
   assign rc_word = {8'h01, rc, 16'h0000, 8'h02, rc, 16'h0000,
                     8'h04, rc, 16'h0000, 8'h08, rc, 16'h0000};

   assign round_key = lanes.key ^ lanes.tweak ^ lanes.cnt ^ rc_word;

   assign next_lanes = '{key:   lfsr3(perm_h(lanes.key)),
                         tweak: lfsr2(perm_h(lanes.tweak)),
                         cnt:   perm_h(lanes.cnt)};   // Counter lane is only permuted

endmodule

`default_nettype wire

//--- rtl/deoxys_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "deoxys_cfg.svh"

module deoxys_ctrl (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   in_valid,
   output logic                   in_ready,
   input  deoxys_pkg::job_t       in_job,
   output logic                   out_valid,
   input  logic                   out_ready,
   output deoxys_pkg::block_t     out_data,
   output deoxys_pkg::block_t     state,
   output deoxys_pkg::tweakey_t   lanes,
   output deoxys_pkg::round_idx_t round_idx,
   input  deoxys_pkg::block_t     round_key,
   input  deoxys_pkg::tweakey_t   next_lanes,
   input  deoxys_pkg::block_t     round_out
);

   localparam deoxys_pkg::round_idx_t LAST_RND = deoxys_pkg::round_idx_t'(`DEOXYS_ROUNDS - 1);

   deoxys_pkg::ctrl_state_e fsm;
   deoxys_pkg::ctrl_state_e fsm_nxt;
   deoxys_pkg::round_idx_t  cnt;
   deoxys_pkg::block_t      state_q;
   deoxys_pkg::tweakey_t    lanes_q;
   logic                    accept;
   logic                    out_xfer;

   assign in_ready  = (fsm == deoxys_pkg::IDLE);
   assign out_valid = (fsm == deoxys_pkg::DONE);
   assign accept    = in_valid & in_ready;
   assign out_xfer  = out_valid & out_ready;

   always_comb begin
      fsm_nxt = fsm;
      case (fsm)
         deoxys_pkg::IDLE: begin
            if (accept) begin
               fsm_nxt = deoxys_pkg::RUN;
            end
         end
         deoxys_pkg::RUN: begin
            if (cnt == LAST_RND) begin
               fsm_nxt = deoxys_pkg::DONE;
            end
         end
         deoxys_pkg::DONE: begin
            if (out_xfer) begin
               fsm_nxt = deoxys_pkg::IDLE;
            end
         end
         default: begin
            fsm_nxt = deoxys_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fsm <= deoxys_pkg::IDLE;
         cnt <= '0;
      end else begin
         fsm <= fsm_nxt;
         if (accept) begin
            cnt <= '0;
         end else if (fsm == deoxys_pkg::RUN) begin
            cnt <= cnt + 1'b1;   // Ends at 16 for the final key
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         state_q <= in_job.pt;
         lanes_q <= in_job.tk;
      end else if (fsm == deoxys_pkg::RUN) begin
         state_q <= round_out;
         lanes_q <= next_lanes;
      end
   end

   assign state     = state_q;
   assign lanes     = lanes_q;
   assign round_idx = cnt;

   // Registers hold still in DONE, so the ciphertext stays stable
   assign out_data = state_q ^ round_key;

endmodule

`default_nettype wire

//--- rtl/deoxys_core.sv
`timescale 1ns/1ns
`default_nettype none

module deoxys_core (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               in_valid,
   output logic               in_ready,
   input  deoxys_pkg::job_t   in_job,
   output logic               out_valid,
   input  logic               out_ready,
   output deoxys_pkg::block_t out_data
);

   deoxys_pkg::block_t     state;
   deoxys_pkg::tweakey_t   lanes;
   deoxys_pkg::round_idx_t round_idx;
   deoxys_pkg::block_t     round_key;
   deoxys_pkg::tweakey_t   next_lanes;
   deoxys_pkg::block_t     round_out;

   deoxys_ctrl u_ctrl (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_job     (in_job),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_data   (out_data),
      .state      (state),
      .lanes      (lanes),
      .round_idx  (round_idx),
      .round_key  (round_key),
      .next_lanes (next_lanes),
      .round_out  (round_out)
   );

   deoxys_tweakey u_tweakey (
      .lanes      (lanes),
      .round_idx  (round_idx),
      .round_key  (round_key),
      .next_lanes (next_lanes)
   );

   deoxys_round u_round (
      .state     (state),
      .round_key (round_key),
      .round_out (round_out)
   );

endmodule

`default_nettype wire

//--- bench/deoxys_chk.sv
`timescale 1ns/1ns
`default_nettype none
`include "deoxys_cfg.svh"

module deoxys_chk (
   input logic               clk,
   input logic               arst_n,
   input logic               in_valid,
   input logic               in_ready,
   input logic               out_valid,
   input logic               out_ready,
   input deoxys_pkg::block_t out_data
);

   int unsigned fails = 0;
   logic        accept;
   logic        out_xfer;

   assign accept   = in_valid & in_ready;
   assign out_xfer = out_valid & out_ready;

   reset_idle: assert property (@(posedge clk) !arst_n |-> !out_valid && in_ready)
      else begin fails++; $error("Core not idle during reset"); end

   // Exactly one round per cycle
   latency: assert property (@(posedge clk) disable iff (!arst_n)
      accept |=> (!out_valid) [*`DEOXYS_ROUNDS] ##1 out_valid)
      else begin fails++; $error("out_valid not raised 16 cycles after acceptance"); end

   hold_out: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
      else begin fails++; $error("Output dropped or changed under back-pressure"); end

   busy_after_accept: assert property (@(posedge clk) disable iff (!arst_n)
      accept |=> !in_ready)
      else begin fails++; $error("in_ready high right after acceptance"); end

   busy_until_xfer: assert property (@(posedge clk) disable iff (!arst_n)
      !in_ready && !out_xfer |=> !in_ready)
      else begin fails++; $error("in_ready rose before the output transferred"); end

   idle_after_xfer: assert property (@(posedge clk) disable iff (!arst_n)
      out_xfer |=> in_ready && !out_valid)
      else begin fails++; $error("Core not idle after output transfer"); end

endmodule

`default_nettype wire

//--- bench/deoxys_ref.svh
`ifndef DEOXYS_REF_SVH
`define DEOXYS_REF_SVH

`include "deoxys_cfg.svh"

// Round constants by round index, last one for the final key add
localparam logic [7:0] RC_TABLE [0:16] = '{
   8'h2f, 8'h5e, 8'hbc, 8'h63, 8'hc6, 8'h97, 8'h35, 8'h6a,
   8'hd4, 8'hb3, 8'h7d, 8'hfa, 8'hef, 8'hc5, 8'h91, 8'h39,
   8'h72
};

// Source byte of h, for output byte 15 down to 0
localparam int H_SRC [15:0] = '{2, 1, 0, 3, 15, 14, 13, 12, 8, 11, 10, 9, 5, 4, 7, 6};

// Product in GF(2^8), AES polynomial
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
   logic [7:0] p;
   logic [7:0] aa;
   p  = 8'h00;
   aa = a;
   for (int i = 0; i < 8; i++) begin
      if (b[i]) p = p ^ aa;
      aa = aa[7] ? ((aa << 1) ^ 8'h1b) : (aa << 1);
   end
   return p;
endfunction

function automatic logic [7:0] sub_byte(input logic [7:0] x);
   logic [7:0] ex;
   logic [7:0] inv;
   logic [7:0] sq;
   ex  = 8'd254;   // x^254 is the inverse, zero stays zero
   inv = 8'h01;
   sq  = x;
   for (int e = 0; e < 8; e++) begin
      if (ex[e]) inv = gf_mul(inv, sq);
      sq = gf_mul(sq, sq);
   end
   return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
              ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

function automatic deoxys_pkg::block_t tweakey_word(input deoxys_pkg::tweakey_t tk,
                                                     input int idx);
   deoxys_pkg::block_t c;
   c = '0;
   for (int col = 0; col < 4; col++) begin
      c[(15-4*col)*8 +: 8] = 8'h01 << col;
      c[(14-4*col)*8 +: 8] = RC_TABLE[idx];
   end
   return tk.key ^ tk.tweak ^ tk.cnt ^ c;
endfunction

function automatic deoxys_pkg::tweakey_t lane_step(input deoxys_pkg::tweakey_t tk);
   deoxys_pkg::tweakey_t r;
   logic [7:0]           k;
   logic [7:0]           t;
   for (int n = 0; n < 16; n++) begin
      k = tk.key[H_SRC[n]*8 +: 8];
      t = tk.tweak[H_SRC[n]*8 +: 8];
      r.key[n*8 +: 8]   = {k[0] ^ k[6], k[7:1]};
      r.tweak[n*8 +: 8] = {t[6:0], t[7] ^ t[5]};
      r.cnt[n*8 +: 8]   = tk.cnt[H_SRC[n]*8 +: 8];
   end
   return r;
endfunction

function automatic deoxys_pkg::block_t cipher_round(input deoxys_pkg::block_t s,
                                                     input deoxys_pkg::block_t rk);
   deoxys_pkg::block_t t;
   logic [31:0]        w [4];
   logic [31:0]        m [4];
   t = s ^ rk;
   for (int b = 0; b < 16; b++) t[b*8 +: 8] = sub_byte(t[b*8 +: 8]);
   for (int k = 0; k < 4; k++) begin
      w[k] = t[k*32 +: 32];
      if (k < 3) w[k] = (w[k] << (8*(3-k))) | (w[k] >> (8*(k+1)));   // Row rotate left
   end
   for (int k = 0; k < 4; k++) begin
      for (int j = 0; j < 4; j++) begin
         m[k][j*8 +: 8] = gf_mul(8'h02, w[k][j*8 +: 8]) ^ gf_mul(8'h03, w[(k+3)%4][j*8 +: 8])
                          ^ w[(k+2)%4][j*8 +: 8] ^ w[(k+1)%4][j*8 +: 8];
      end
   end
   return {m[3], m[2], m[1], m[0]};
endfunction

function automatic deoxys_pkg::block_t encrypt_block(input deoxys_pkg::job_t job);
   deoxys_pkg::block_t   s;
   deoxys_pkg::tweakey_t tk;
   s  = job.pt;
   tk = job.tk;
   for (int r = 0; r < `DEOXYS_ROUNDS; r++) begin
      s  = cipher_round(s, tweakey_word(tk, r));
      tk = lane_step(tk);
   end
   return s ^ tweakey_word(tk, `DEOXYS_ROUNDS);
endfunction

`endif

//--- bench/tb_deoxys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_deoxys;

   localparam int NJOBS   = 40;
   localparam int TIMEOUT = 2000;   // 40 jobs of up to 17 + 8 cycles plus margin

   logic               clk;
   logic               arst_n;
   logic               in_valid;
   logic               in_ready;
   deoxys_pkg::job_t   in_job;
   logic               out_valid;
   logic               out_ready;
   deoxys_pkg::block_t out_data;

   deoxys_pkg::block_t exp_q [$];
   string              name_q [$];
   deoxys_pkg::block_t exp_blk;
   string              test_name;
   int                 errors   = 0;
   int                 done_cnt = 0;
   int                 cycles   = 0;

   `include "deoxys_ref.svh"

   deoxys_core dut0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_job    (in_job),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data)
   );

   bind deoxys_core deoxys_chk chk0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic deoxys_pkg::job_t random_job();
      deoxys_pkg::job_t j;
      for (int w = 0; w < $bits(deoxys_pkg::job_t) / 32; w++) j[w*32 +: 32] = $urandom();
      return j;
   endfunction

   // Holds in_valid until accepted and may put junk on in_job while busy
   task automatic send_job(input deoxys_pkg::job_t job, input bit scramble, input string name);
      in_valid <= 1'b1;
      in_job   <= scramble ? random_job() : job;
      @(posedge clk);
      while (!in_ready) begin
         if (scramble && !(out_valid && out_ready)) in_job <= random_job();
         else in_job <= job;   // Core frees up after this edge
         @(posedge clk);
      end
      exp_q.push_back(encrypt_block(job));
      name_q.push_back(name);
   endtask

   initial begin
      void'($urandom(32'h1a33_b354));
      arst_n   = 1'b1;
      in_valid = 1'b0;
      in_job   = '0;
      #1;
      arst_n = 1'b0;
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      assert (!out_valid && in_ready) else begin
         errors++;
         $display("[FAIL] reset_state expected 01 actual %b%b", out_valid, in_ready);
      end
      send_job('0, 1'b0, "zero_job");
      for (int i = 1; i < NJOBS; i++) begin
         send_job(random_job(), (i % 3) == 0, $sformatf("random_job_%0d", i));
      end
      in_valid <= 1'b0;
      wait (done_cnt == NJOBS);
      repeat (2) @(posedge clk);
      $display("Errors: %0d scoreboard, %0d assertion, %0d of %0d jobs checked",
               errors, dut0.chk0.fails, done_cnt, NJOBS);
      if (errors == 0 && dut0.chk0.fails == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // Random back-pressure in stretches of 1 to 8 cycles
   initial begin
      int stall;
      stall     = 0;
      out_ready = 1'b0;
      forever begin
         @(posedge clk);
         if (stall != 0) begin
            out_ready <= 1'b0;
            stall--;
         end else begin
            out_ready <= 1'b1;
            if ($urandom_range(0, 2) == 0) stall = $urandom_range(1, 8);
         end
      end
   end

   always @(posedge clk) begin
      if (arst_n && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("Output transferred while no job was outstanding");
         end else begin
            exp_blk   = exp_q.pop_front();
            test_name = name_q.pop_front();
            assert (out_data == exp_blk) else begin
               errors++;
               $display("[FAIL] %s expected %h actual %h", test_name, exp_blk, out_data);
            end
         end
         done_cnt++;
      end
   end

   initial begin
      while (cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles with %0d of %0d jobs done", cycles, done_cnt, NJOBS);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+rtl
+incdir+bench
rtl/deoxys_pkg.sv
rtl/deoxys_sbox.sv
rtl/deoxys_round.sv
rtl/deoxys_tweakey.sv
rtl/deoxys_ctrl.sv
rtl/deoxys_core.sv
bench/deoxys_chk.sv
bench/tb_deoxys.sv
